/* compile.f */
logic/boot_pkg.sv
logic/mem_bus_if.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/word_loader.sv
logic/readback_sender.sv
logic/bus_arbiter.sv
logic/word_memory.sv
logic/boot_top.sv
test/tb_boot.sv

/* test/tb_boot.sv */
`timescale 1ns/10ps

module tb_boot;
   import boot_pkg::*;

   localparam int clks_per_bit = 8;
   localparam int mem_depth    = 64;
   // words per test including markers, host side and readback side
   localparam int frames_sent  = (21 + 11 + 1 + 71 + 9 + 6) * 4;
   localparam int frames_back  = (21 + 11 + 1 + 65 + 9 + 6) * 4;
   localparam int cycle_limit  = 2 * (frames_sent + frames_back) * 10 * clks_per_bit + 1000;

   logic  clk;
   logic  reset;
   logic  rs_rx;
   logic  rs_tx;
   addr_t loaded_words;
   logic  busy;

   logic [31:0] lfsr;
   byte_t       rx_bytes[$];
   word_t       image[$];
   word_t       model_mem[mem_depth];
   addr_t       model_count;
   string       test_name;
   int          errors;
   int          errors_at_start;
   int          tests_run;
   int          tests_failed;
   int          cycles;

   boot_top #(
      .clks_per_bit(clks_per_bit),
      .mem_depth   (mem_depth)
   ) uut (
      .clk         (clk),
      .reset       (reset),
      .rs_rx       (rs_rx),
      .rs_tx       (rs_tx),
      .loaded_words(loaded_words),
      .busy        (busy)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // galois form, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         val  = {val[30:0], lfsr[0]};
         lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
      end
      return val;
   endfunction

   function automatic word_t random_word();
      word_t w;
      w = rand_bits(32);
      // a random marker would end the image early
      if (w == end_marker) begin
         w = '0;
      end
      return w;
   endfunction

   task automatic compare_word(input string what, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, expected, actual);
         errors++;
      end
   endtask

   task automatic compare_count(input string what, input addr_t expected, input addr_t actual);
      if (actual !== expected) begin
         $display("MISMATCH %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
         errors++;
      end
   endtask

   task automatic compare_bit(input string what, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("MISMATCH %s %s: expected %b, actual %b", test_name, what, expected, actual);
         errors++;
      end
   endtask

   task automatic begin_test(input string name);
      test_name       = name;
      errors_at_start = errors;
      tests_run++;
   endtask

   task automatic end_test();
      if (errors == errors_at_start) begin
         $display("%s: ok", test_name);
      end else begin
         tests_failed++;
         $display("%s: %0d errors", test_name, errors - errors_at_start);
      end
   endtask

   // one bit period, entered right after a rising edge
   task automatic drive_bit(input logic value);
      rs_rx <= value;
      repeat (clks_per_bit) @(posedge clk);
   endtask

   task automatic send_byte(input byte_t data, input int gap_bits);
      repeat (gap_bits * clks_per_bit) @(posedge clk);
      drive_bit(1'b0);
      for (int i = 0; i < 8; i++) begin
         drive_bit(data[i]);
      end
      drive_bit(1'b1);
   endtask

   task automatic send_word(input word_t w, input logic gaps);
      for (int i = 3; i >= 0; i--) begin
         send_byte(w[8*i +: 8], gaps ? int'(rand_bits(4)) : 0);
      end
   endtask

   task automatic fill_image(input int n);
      image.delete();
      for (int i = 0; i < n; i++) begin
         image.push_back(random_word());
      end
   endtask

   // words past the end of the memory are dropped
   task automatic model_load();
      model_count = '0;
      foreach (image[i]) begin
         if (model_count < mem_depth) begin
            model_mem[model_count] = image[i];
            model_count++;
         end
      end
   endtask

   task automatic wait_busy(input logic level, input int limit, output logic seen);
      int n;
      n    = 0;
      seen = 1'b0;
      while (!seen && n < limit) begin
         @(negedge clk);
         seen = (busy === level);
         n++;
      end
      @(posedge clk);
   endtask

   task automatic run_image(input logic gaps);
      word_t expected[$];
      word_t sum;
      word_t got;
      logic  seen;
      int    need;
      int    n;
      model_load();
      sum = '0;
      for (int i = 0; i < model_count; i++) begin
         expected.push_back(model_mem[i]);
         sum += model_mem[i];
      end
      expected.push_back(sum);
      need = expected.size() * 4;
      rx_bytes.delete();
      foreach (image[i]) begin
         send_word(image[i], gaps);
      end
      send_word(end_marker, gaps);
      wait_busy(1'b1, 4 * clks_per_bit, seen);
      if (!seen) begin
         $display("%s: readback never started after the end marker", test_name);
         errors++;
      end
      wait_busy(1'b0, need * 12 * clks_per_bit, seen);
      if (!seen) begin
         $display("%s: readback still busy long after its last byte was due", test_name);
         errors++;
      end
      // last frame is still on the line when busy drops
      n = 0;
      while (rx_bytes.size() < need && n < 20 * clks_per_bit) begin
         @(posedge clk);
         n++;
      end
      compare_count("loaded_words", model_count, loaded_words);
      compare_count("readback bytes", addr_t'(need), addr_t'(rx_bytes.size()));
      for (int i = 0; i < expected.size() && 4 * i + 3 < rx_bytes.size(); i++) begin
         got = {rx_bytes[4*i], rx_bytes[4*i+1], rx_bytes[4*i+2], rx_bytes[4*i+3]};
         compare_word($sformatf("word %0d", i), expected[i], got);
      end
   endtask

   // rs_tx decoded at falling edges, half a cycle from any update
   initial begin : monitor
      byte_t data;
      forever begin
         @(negedge clk);
         if (rs_tx === 1'b0) begin
            repeat (clks_per_bit / 2) @(negedge clk);
            for (int i = 0; i < 8; i++) begin
               repeat (clks_per_bit) @(negedge clk);
               data[i] = rs_tx;
            end
            repeat (clks_per_bit) @(negedge clk);
            if (rs_tx !== 1'b1) begin
               $display("%s: rs_tx frame ended with a low stop bit", test_name);
               errors++;
            end
            rx_bytes.push_back(data);
         end
      end
   end

   initial begin : watchdog
      cycles = 0;
      while (cycles < cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout after %0d cycles, the run did not finish", cycles);
      $display("Testbench failed");
      $finish;
   end

   initial begin
      reset        = 1'b1;
      rs_rx        = 1'b1;
      lfsr         = 32'h47bd_5e7a;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      test_name    = "reset";
      repeat (5) @(posedge clk);
      reset <= 1'b0;

      begin_test("reset state");
      for (int i = 0; i < 50; i++) begin
         @(negedge clk);
         compare_bit("rs_tx", 1'b1, rs_tx);
         compare_bit("busy", 1'b0, busy);
         compare_count("loaded_words", '0, loaded_words);
      end
      @(posedge clk);
      end_test();

      begin_test("image of 20 words");
      fill_image(20);
      run_image(1'b0);
      end_test();

      begin_test("10 words with idle gaps");
      fill_image(10);
      run_image(1'b1);
      end_test();

      begin_test("marker only");
      fill_image(0);
      run_image(1'b0);
      end_test();

      begin_test("70 words into 64");
      fill_image(70);
      run_image(1'b0);
      end_test();

      // shorter second image leaves stale words above its count
      begin_test("second image replaces first");
      fill_image(8);
      run_image(1'b0);
      fill_image(5);
      run_image(1'b0);
      end_test();

      $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

/* logic/boot_top.sv */
`timescale 1ns/10ps

module boot_top #(
   parameter int clks_per_bit = 8,
   parameter int mem_depth    = 64
) (
   input  logic            clk,
   input  logic            reset,
   input  logic            rs_rx,
   output logic            rs_tx,
   output boot_pkg::addr_t loaded_words,
   output logic            busy
);
   import boot_pkg::*;

   byte_t rx_data;
   logic  rx_valid;
   byte_t tx_data;
   logic  tx_valid;
   logic  tx_ready;
   logic  load_done;

   mem_bus_if load_bus ();
   mem_bus_if read_bus ();
   mem_bus_if mem_bus ();

   uart_rx #(
      .clks_per_bit(clks_per_bit)
   ) u_rx (
      .clk     (clk),
      .reset   (reset),
      .rx      (rs_rx),
      .rx_data (rx_data),
      .rx_valid(rx_valid)
   );

   word_loader #(
      .mem_depth(mem_depth)
   ) u_loader (
      .clk         (clk),
      .reset       (reset),
      .rx_data     (rx_data),
      .rx_valid    (rx_valid),
      .bus         (load_bus.master),
      .loaded_words(loaded_words),
      .load_done   (load_done)
   );

   // loader and readback share the memory
   bus_arbiter u_arb (
      .clk     (clk),
      .reset   (reset),
      .load_bus(load_bus.slave),
      .read_bus(read_bus.slave),
      .mem_bus (mem_bus.master)
   );

   word_memory #(
      .mem_depth(mem_depth)
   ) u_mem (
      .clk  (clk),
      .reset(reset),
      .bus  (mem_bus.slave)
   );

   readback_sender u_readback (
      .clk       (clk),
      .reset     (reset),
      .load_done (load_done),
      .word_count(loaded_words),
      .bus       (read_bus.master),
      .tx_data   (tx_data),
      .tx_valid  (tx_valid),
      .tx_ready  (tx_ready),
      .busy      (busy)
   );

   uart_tx #(
      .clks_per_bit(clks_per_bit)
   ) u_tx (
      .clk     (clk),
      .reset   (reset),
      .tx_data (tx_data),
      .tx_valid(tx_valid),
      .tx_ready(tx_ready),
      .tx      (rs_tx)
   );

endmodule

/* logic/word_memory.sv */
`timescale 1ns/10ps

module word_memory #(
   parameter int mem_depth = 64
) (
   input  logic     clk,
   input  logic     reset,
   mem_bus_if.slave bus
);
   import boot_pkg::*;

   localparam int aw = $clog2(mem_depth);

   word_t         mem [mem_depth];
   // high in the second access cycle
   logic          waited;
   logic [aw-1:0] index;
   logic          first_access;
   word_t         rd_word;

   assign index        = bus.paddr[aw-1:0];
   assign first_access = bus.psel && bus.penable && !waited;

   assign bus.pready = bus.psel && bus.penable && waited;
   assign bus.prdata = rd_word;

   always_ff @(posedge clk) begin
      if (reset) begin
         waited <= 1'b0;
      end else begin
         waited <= first_access;
      end
   end

   // read during the wait state so data lines up with pready
   always_ff @(posedge clk) begin
      if (first_access) begin
         rd_word <= mem[index];
      end
      if (bus.pready && bus.pwrite) begin
         mem[index] <= bus.pwdata;
      end
   end

endmodule

/* logic/bus_arbiter.sv */
`timescale 1ns/10ps

module bus_arbiter (
   input  logic      clk,
   input  logic      reset,
   mem_bus_if.slave  load_bus,
   mem_bus_if.slave  read_bus,
   mem_bus_if.master mem_bus
);

   logic locked;
   logic owner_rd;
   logic grant_rd;
   logic granted_enable;

   // loader has priority whenever the bus is free
   always_comb begin
      if (locked) begin
         grant_rd = owner_rd;
      end else begin
         grant_rd = !load_bus.psel && read_bus.psel;
      end
   end

   assign granted_enable = grant_rd ? read_bus.penable : load_bus.penable;

   assign mem_bus.psel   = grant_rd ? read_bus.psel : load_bus.psel;
   // a master that waited in access still gives the slave a setup cycle
   assign mem_bus.penable = locked && granted_enable;
   assign mem_bus.pwrite = grant_rd ? read_bus.pwrite : load_bus.pwrite;
   assign mem_bus.paddr  = grant_rd ? read_bus.paddr : load_bus.paddr;
   assign mem_bus.pwdata = grant_rd ? read_bus.pwdata : load_bus.pwdata;

   // losing master sees pready low and keeps waiting
   assign load_bus.prdata = mem_bus.prdata;
   assign read_bus.prdata = mem_bus.prdata;
   assign load_bus.pready = mem_bus.pready && !grant_rd;
   assign read_bus.pready = mem_bus.pready && grant_rd;

   always_ff @(posedge clk) begin
      if (reset) begin
         locked   <= 1'b0;
         owner_rd <= 1'b0;
      end else if (mem_bus.psel && !(mem_bus.penable && mem_bus.pready)) begin
         locked   <= 1'b1;
         owner_rd <= grant_rd;
      end else begin
         locked <= 1'b0;
      end
   end

   // a started transfer keeps its master, address and data until pready
   a_grant_held : assert property (@(posedge clk) disable iff (reset)
      mem_bus.psel && mem_bus.penable && !mem_bus.pready
      |=> mem_bus.psel && mem_bus.penable && $stable(mem_bus.paddr)
          && $stable(mem_bus.pwrite) && $stable(mem_bus.pwdata))
      else $error("bus_arbiter: grant moved during a transfer");

endmodule

/* logic/readback_sender.sv */
`timescale 1ns/10ps

module readback_sender (
   input  logic            clk,
   input  logic            reset,
   input  logic            load_done,
   input  boot_pkg::addr_t word_count,
   mem_bus_if.master       bus,
   output boot_pkg::byte_t tx_data,
   output logic            tx_valid,
   input  logic            tx_ready,
   output logic            busy
);
   import boot_pkg::*;

   typedef enum logic [1:0] {
      s_idle,
      s_fetch,
      s_word,
      s_sum
   } rb_state_e;

   rb_state_e  state;
   apb_phase_e phase;
   addr_t      count;
   addr_t      rd_addr;
   word_t      checksum;
   // byte on offer sits in the top 8 bits
   word_t      out_sr;
   logic [1:0] byte_idx;
   logic       byte_taken;
   logic       last_byte;
   logic       last_word;
   logic       read_done;

   assign busy       = state != s_idle;
   assign tx_valid   = state == s_word || state == s_sum;
   assign tx_data    = out_sr[31:24];
   assign byte_taken = tx_valid && tx_ready;
   assign last_byte  = byte_taken && byte_idx == 2'd3;
   assign last_word  = rd_addr + addr_t'(1) == count;
   assign read_done  = state == s_fetch && phase == access && bus.pready;

   // read only master
   assign bus.psel    = phase != idle;
   assign bus.penable = phase == access;
   assign bus.pwrite  = 1'b0;
   assign bus.paddr   = rd_addr;
   assign bus.pwdata  = '0;

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= s_idle;
         phase    <= idle;
         rd_addr  <= '0;
         byte_idx <= '0;
      end else begin
         if (byte_taken) begin
            byte_idx <= byte_idx + 2'd1;
         end
         case (state)
            s_idle: begin
               if (load_done) begin
                  rd_addr  <= '0;
                  byte_idx <= '0;
                  if (word_count == '0) begin
                     // nothing stored, only the zero checksum goes out
                     state <= s_sum;
                  end else begin
                     state <= s_fetch;
                     phase <= setup;
                  end
               end
            end
            s_fetch: begin
               if (phase == setup) begin
                  phase <= access;
               end else if (read_done) begin
                  phase <= idle;
                  state <= s_word;
               end
            end
            s_word: begin
               if (last_byte) begin
                  if (last_word) begin
                     state <= s_sum;
                  end else begin
                     rd_addr <= rd_addr + addr_t'(1);
                     state   <= s_fetch;
                     phase   <= setup;
                  end
               end
            end
            s_sum: begin
               if (last_byte) begin
                  state <= s_idle;
               end
            end
            default: state <= s_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == s_idle && load_done) begin
         count    <= word_count;
         checksum <= '0;
         out_sr   <= '0;
      end else if (read_done) begin
         out_sr   <= bus.prdata;
         checksum <= checksum + bus.prdata;
      end else if (byte_taken) begin
         // checksum already holds the last word here
         if (state == s_word && byte_idx == 2'd3 && last_word) begin
            out_sr <= checksum;
         end else begin
            out_sr <= {out_sr[23:0], 8'h00};
         end
      end
   end

   a_offer_held : assert property (@(posedge clk) disable iff (reset)
      tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
      else $error("readback_sender: byte withdrawn before accept");

endmodule

/* logic/word_loader.sv */
`timescale 1ns/10ps

module word_loader #(
   parameter int mem_depth = 64
) (
   input  logic            clk,
   input  logic            reset,
   input  boot_pkg::byte_t rx_data,
   input  logic            rx_valid,
   mem_bus_if.master       bus,
   output boot_pkg::addr_t loaded_words,
   output logic            load_done
);
   import boot_pkg::*;

   localparam addr_t depth = addr_t'(mem_depth);

   apb_phase_e phase;
   logic [1:0] byte_cnt;
   // set between images, the next word starts again at address 0
   logic       fresh;
   word_t      word_sr;
   word_t      next_word;
   addr_t      next_addr;
   logic       word_end;
   logic       can_write;

   // msb first, so each byte pushes the older ones up
   assign next_word = {word_sr[23:0], rx_data};
   assign word_end  = rx_valid && byte_cnt == 2'd3;
   assign next_addr = fresh ? '0 : loaded_words;
   // once full, later words are dropped
   assign can_write = fresh || loaded_words < depth;

   // loader only ever writes
   assign bus.psel    = phase != idle;
   assign bus.penable = phase == access;
   assign bus.pwrite  = 1'b1;
   assign bus.paddr   = next_addr;
   // word_sr next moves a whole frame later, well after the write ends
   assign bus.pwdata  = word_sr;

   always_ff @(posedge clk) begin
      if (reset) begin
         phase        <= idle;
         byte_cnt     <= '0;
         fresh        <= 1'b1;
         loaded_words <= '0;
         load_done    <= 1'b0;
      end else begin
         load_done <= 1'b0;
         if (rx_valid) begin
            byte_cnt <= byte_cnt + 2'd1;
         end
         case (phase)
            idle: begin
               if (word_end) begin
                  if (next_word == end_marker) begin
                     load_done <= 1'b1;
                     fresh     <= 1'b1;
                     // marker with no words before it is an empty image
                     if (fresh) begin
                        loaded_words <= '0;
                     end
                  end else if (can_write) begin
                     phase <= setup;
                  end
               end
            end
            setup: phase <= access;
            access: begin
               if (bus.pready) begin
                  phase        <= idle;
                  fresh        <= 1'b0;
                  loaded_words <= next_addr + addr_t'(1);
               end
            end
            default: phase <= idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rx_valid) begin
         word_sr <= next_word;
      end
   end

   a_addr_in_range : assert property (@(posedge clk) disable iff (reset)
      bus.psel |-> bus.paddr < depth)
      else $error("word_loader: write outside the memory");

endmodule

/* logic/uart_tx.sv */
`timescale 1ns/10ps

module uart_tx #(
   parameter int clks_per_bit = 8
) (
   input  logic            clk,
   input  logic            reset,
   input  boot_pkg::byte_t tx_data,
   input  logic            tx_valid,
   output logic            tx_ready,
   output logic            tx
);

   localparam int cnt_w = $clog2(clks_per_bit + 1);

   typedef logic [cnt_w-1:0] cnt_t;

   localparam cnt_t full_bit = cnt_t'(clks_per_bit - 1);

   // stop, data lsb first, start; bit 0 is on the line
   logic [9:0] frame;
   logic       sending;
   cnt_t       timer;
   logic [3:0] bit_idx;

   assign tx_ready = !sending;
   assign tx       = frame[0];

   always_ff @(posedge clk) begin
      if (reset) begin
         frame   <= '1;
         sending <= 1'b0;
         timer   <= '0;
         bit_idx <= '0;
      end else if (!sending) begin
         if (tx_valid) begin
            frame   <= {1'b1, tx_data, 1'b0};
            sending <= 1'b1;
            timer   <= '0;
            bit_idx <= '0;
         end
      end else if (timer == full_bit) begin
         timer <= '0;
         // ones shift in behind the stop bit, leaving the line high
         frame <= {1'b1, frame[9:1]};
         if (bit_idx == 4'd9) begin
            sending <= 1'b0;
         end else begin
            bit_idx <= bit_idx + 4'd1;
         end
      end else begin
         timer <= timer + cnt_t'(1);
      end
   end

endmodule

/* logic/uart_rx.sv */
`timescale 1ns/10ps

module uart_rx #(
   parameter int clks_per_bit = 8
) (
   input  logic            clk,
   input  logic            reset,
   input  logic            rx,
   output boot_pkg::byte_t rx_data,
   output logic            rx_valid
);
   import boot_pkg::*;

   localparam int cnt_w = $clog2(clks_per_bit + 1);

   typedef logic [cnt_w-1:0] cnt_t;

   localparam cnt_t half_bit = cnt_t'(clks_per_bit / 2 - 1);
   localparam cnt_t full_bit = cnt_t'(clks_per_bit - 1);

   typedef enum logic [1:0] {
      st_idle,
      st_start,
      st_bits,
      st_stop
   } rx_state_e;

   rx_state_e  state;
   logic       rx_meta;
   logic       rx_sync;
   cnt_t       timer;
   logic [2:0] bit_idx;
   byte_t      shift;

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= st_idle;
         timer    <= '0;
         bit_idx  <= '0;
         rx_valid <= 1'b0;
         // line idles high, so no false start out of reset
         rx_meta  <= 1'b1;
         rx_sync  <= 1'b1;
      end else begin
         rx_meta  <= rx;
         rx_sync  <= rx_meta;
         rx_valid <= 1'b0;
         case (state)
            st_idle: begin
               if (!rx_sync) begin
                  state <= st_start;
                  timer <= '0;
               end
            end
            st_start: begin
               // recheck at the middle of the start bit
               if (timer == half_bit) begin
                  timer   <= '0;
                  bit_idx <= '0;
                  state   <= rx_sync ? st_idle : st_bits;
               end else begin
                  timer <= timer + cnt_t'(1);
               end
            end
            st_bits: begin
               if (timer == full_bit) begin
                  timer   <= '0;
                  bit_idx <= bit_idx + 3'd1;
                  if (bit_idx == 3'd7) begin
                     state <= st_stop;
                  end
               end else begin
                  timer <= timer + cnt_t'(1);
               end
            end
            st_stop: begin
               if (timer == full_bit) begin
                  state    <= st_idle;
                  // low stop bit means a broken frame, drop it
                  rx_valid <= rx_sync;
               end else begin
                  timer <= timer + cnt_t'(1);
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // data bits arrive lsb first
   always_ff @(posedge clk) begin
      if (state == st_bits && timer == full_bit) begin
         shift <= {rx_sync, shift[7:1]};
      end
      if (state == st_stop && timer == full_bit) begin
         rx_data <= shift;
      end
   end

   a_single_strobe : assert property (@(posedge clk) disable iff (reset)
      rx_valid |=> !rx_valid)
      else $error("uart_rx: rx_valid held for two cycles");

endmodule

/* logic/mem_bus_if.sv */
`timescale 1ns/10ps

interface mem_bus_if;
   import boot_pkg::*;

   // request side
   logic  psel;
   logic  penable;
   logic  pwrite;
   addr_t paddr;
   word_t pwdata;

   // completion side
   word_t prdata;
   logic  pready;

   modport master (
      output psel,
      output penable,
      output pwrite,
      output paddr,
      output pwdata,
      input  prdata,
      input  pready
   );

   modport slave (
      input  psel,
      input  penable,
      input  pwrite,
      input  paddr,
      input  pwdata,
      output prdata,
      output pready
   );

endinterface

/* logic/boot_pkg.sv */
package boot_pkg;

   // one serial character
   typedef logic [7:0] byte_t;

   // image word, also the readback checksum
   typedef logic [31:0] word_t;

   // word address or word count
   typedef logic [15:0] addr_t;

   // host closes every image with this word
   localparam word_t end_marker = 32'hffff_ffff;

   // master side of the APB handshake
   // idle   : no request
   // setup  : psel high, penable low
   // access : penable high until the slave returns pready
   typedef enum logic [1:0] {
      idle,
      setup,
      access
   } apb_phase_e;

endpackage
